// ==== hw/character_params.svh ====
// Arena units for the character controller. The character is a 32x32 box
// and the bounds are its reachable lower-left corners inside the walls.
// All velocities are in arena units per step tick.
`ifndef CHARACTER_PARAMS_SVH
`define CHARACTER_PARAMS_SVH

// ---------------------------------------------------------------------------
// widths
`define PHY_WIDTH        12     // coord/velocity are PHY_WIDTH+1 bits, signed
`define CHARGE_WIDTH     7

// ---------------------------------------------------------------------------
// arena, map offset 270/50 with a 10 unit wall
`define ARENA_X_MIN      280    // left inner wall face
`define ARENA_X_MAX      328    // right inner face 360 minus width 32
`define ARENA_Y_MIN      60     // floor
`define ARENA_Y_MAX      108    // ceiling 140 minus height 32
`define INIT_POS_X       304
`define INIT_POS_Y       84

// ---------------------------------------------------------------------------
// physics
`define MAX_VEL          40
`define GRAVITY          1
`define WALK_STEP        1
`define JUMP_VEL_X       4      // scaled by jump strength 1..4
`define JUMP_VEL_Y       8
`define MAX_CHARGE       100
`define CHARGE_INCREMENT 10

`endif

// ==== hw/arena_pkg.sv ====
// Geometry types of the arena. Both are signed and PHY_WIDTH+1 bits wide,
// so intermediate sums near the walls stay in range without extension.
`default_nettype none

`include "character_params.svh"

package arena_pkg;

    // lower-left corner of the character box
    typedef logic signed [`PHY_WIDTH:0] coord_t;

    // per-step displacement, positive is right/up
    typedef logic signed [`PHY_WIDTH:0] vel_t;

endpackage

`default_nettype wire

// ==== hw/character_pkg.sv ====
// Character state, facing and jump strength types.
`default_nettype none

package character_pkg;

    // movement FSM states
    typedef enum logic [2:0] {
        IDLE,
        WALK_LEFT,
        WALK_RIGHT,
        CHARGE,
        JUMP,
        AIRBORNE        // covers rising, falling and wall bounces
    } char_state_e;

    typedef enum logic {
        FACE_RIGHT,
        FACE_LEFT
    } face_e;

    // launch multiplier, only 1..4 occur
    typedef logic [2:0] jump_strength_t;

endpackage

`default_nettype wire

// ==== hw/button_sync.sv ====
// Button register stage. Buttons must already be debounced and synchronous.
// A jump request stays latched until the FSM takes it.
`timescale 1ns/1ps
`default_nettype none

module button_sync (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic left_btn,
    input  logic right_btn,
    input  logic jump_btn,
    input  logic jump_taken,
    output logic left_held,
    output logic right_held,
    output logic jump_held,
    output logic jump_pending
);

    logic jump_held_d;
    logic jump_rise;

    assign jump_rise = jump_held & ~jump_held_d;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_held    <= 1'b0;
            right_held   <= 1'b0;
            jump_held    <= 1'b0;
            jump_held_d  <= 1'b0;
            jump_pending <= 1'b0;
        end else begin
            left_held   <= left_btn;
            right_held  <= right_btn;
            jump_held   <= jump_btn;
            jump_held_d <= jump_held;
            // a press between step ticks must survive until the FSM sees it
            if (jump_taken) begin
                jump_pending <= 1'b0;
            end else if (jump_rise) begin
                jump_pending <= 1'b1;
            end
        end
    end

    a_pending_needs_edge : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(jump_pending) |-> $past(jump_held && !jump_held_d));

endmodule

`default_nettype wire

// ==== hw/character_fsm.sv ====
// Movement FSM with charge meter and facing. Advances only on step_tick.
// The charge meter stops adding once it reaches MAX_CHARGE.
`timescale 1ns/1ps
`default_nettype none

`include "character_params.svh"

module character_fsm (
    input  logic                        sys_clk,
    input  logic                        sys_rst_n,
    input  logic                        step_tick,
    input  logic                        left_held,
    input  logic                        right_held,
    input  logic                        jump_held,
    input  logic                        jump_pending,
    input  logic                        on_ground,
    input  logic                        side_hit,
    output character_pkg::char_state_e  state,
    output character_pkg::face_e        face,
    output logic [`CHARGE_WIDTH-1:0]    charge,
    output character_pkg::jump_strength_t strength,
    output logic                        jump_taken
);

    import character_pkg::*;

    char_state_e next_state;

    // ------------------------------------------------------------------------
    // next state
    always_comb begin
        case (state)
            IDLE, WALK_LEFT, WALK_RIGHT, AIRBORNE: begin
                if (!on_ground) begin
                    next_state = AIRBORNE;
                end else if (left_held) begin
                    next_state = WALK_LEFT;
                end else if (right_held) begin
                    next_state = WALK_RIGHT;
                end else if (jump_pending) begin
                    next_state = CHARGE;
                end else begin
                    next_state = IDLE;
                end
            end
            CHARGE: begin
                // release or full meter launches
                if (!jump_held || charge >= `MAX_CHARGE) begin
                    next_state = JUMP;
                end else begin
                    next_state = CHARGE;
                end
            end
            JUMP:    next_state = AIRBORNE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state  <= IDLE;
            face   <= FACE_RIGHT;
            charge <= `CHARGE_WIDTH'(1);
        end else if (step_tick) begin
            state <= next_state;

            if (state == CHARGE && charge < `MAX_CHARGE) begin
                charge <= charge + `CHARGE_WIDTH'(`CHARGE_INCREMENT);
            end else if (state == JUMP) begin
                charge <= `CHARGE_WIDTH'(1);
            end

            if (side_hit) begin
                face <= (face == FACE_LEFT) ? FACE_RIGHT : FACE_LEFT; // wall bounce
            end else if (state == WALK_LEFT) begin
                face <= FACE_LEFT;
            end else if (state == WALK_RIGHT) begin
                face <= FACE_RIGHT;
            end
        end
    end

    // ------------------------------------------------------------------------
    // strength by quarters of the meter
    always_comb begin
        if (charge <= `MAX_CHARGE / 4) begin
            strength = 3'd1;
        end else if (charge <= `MAX_CHARGE * 2 / 4) begin
            strength = 3'd2;
        end else if (charge <= `MAX_CHARGE * 3 / 4) begin
            strength = 3'd3;
        end else begin
            strength = 3'd4;
        end
    end

    assign jump_taken = (state == CHARGE); // drops the latched request

    a_state_legal : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        state inside {IDLE, WALK_LEFT, WALK_RIGHT, CHARGE, JUMP, AIRBORNE});

    a_charge_bound : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        charge <= `MAX_CHARGE + `CHARGE_INCREMENT);

endmodule

`default_nettype wire

// ==== hw/character_physics.sv ====
// Integer physics of the character: gravity, launch, bounces and clamping.
// Walls are the arena bounds only; there are no obstacles inside the arena.
// Velocity is clamped before it is added to the position.
`timescale 1ns/1ps
`default_nettype none

`include "character_params.svh"

module character_physics (
    input  logic                          sys_clk,
    input  logic                          sys_rst_n,
    input  logic                          step_tick,
    input  character_pkg::char_state_e    state,
    input  character_pkg::face_e          face,
    input  character_pkg::jump_strength_t strength,
    output arena_pkg::coord_t             pos_x,
    output arena_pkg::coord_t             pos_y,
    output arena_pkg::vel_t               vel_x,
    output arena_pkg::vel_t               vel_y,
    output logic                          on_ground,
    output logic                          side_hit
);

    import arena_pkg::*;
    import character_pkg::*;

    localparam coord_t X_MIN = `ARENA_X_MIN;
    localparam coord_t X_MAX = `ARENA_X_MAX;
    localparam coord_t Y_MIN = `ARENA_Y_MIN;
    localparam coord_t Y_MAX = `ARENA_Y_MAX;
    localparam vel_t   V_MAX = `MAX_VEL;

    vel_t   launch_x_mag;
    vel_t   launch_y;
    vel_t   vel_x_raw, vel_y_raw;
    vel_t   vel_x_next, vel_y_next;
    coord_t walk_ofs;
    coord_t pos_x_next, pos_y_next;

    function automatic vel_t clamp_vel(input vel_t v);
        if (v > V_MAX) begin
            return V_MAX;
        end else if (v < -V_MAX) begin
            return -V_MAX;
        end
        return v;
    endfunction

    function automatic coord_t clamp_coord(input coord_t v, input coord_t lo, input coord_t hi);
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // contact flags, straight from the registers
    assign on_ground = (pos_y == Y_MIN);
    assign side_hit  = (pos_x == X_MIN && vel_x < 0) || (pos_x == X_MAX && vel_x > 0);

    assign launch_x_mag = vel_t'(`JUMP_VEL_X * strength);
    assign launch_y     = vel_t'(`JUMP_VEL_Y * strength);

    // ------------------------------------------------------------------------
    // velocity update
    always_comb begin
        if (state == JUMP) begin
            vel_x_raw = (face == FACE_LEFT) ? -launch_x_mag : launch_x_mag;
        end else if (side_hit) begin
            vel_x_raw = -vel_x;                 // bounce off side wall
        end else if (on_ground) begin
            vel_x_raw = '0;                     // friction stops ground slide
        end else begin
            vel_x_raw = vel_x;
        end

        if (state == JUMP) begin
            vel_y_raw = launch_y;
        end else if (on_ground && vel_y <= 0) begin
            vel_y_raw = '0;                     // landed
        end else if (pos_y == Y_MAX && vel_y > 0) begin
            vel_y_raw = -vel_y;                 // ceiling bounce
        end else begin
            vel_y_raw = vel_y - vel_t'(`GRAVITY);
        end

        vel_x_next = clamp_vel(vel_x_raw);
        vel_y_next = clamp_vel(vel_y_raw);
    end

    // ------------------------------------------------------------------------
    // position update
    always_comb begin
        case (state)
            WALK_LEFT:  walk_ofs = -coord_t'(`WALK_STEP);
            WALK_RIGHT: walk_ofs = coord_t'(`WALK_STEP);
            default:    walk_ofs = '0;
        endcase
        pos_x_next = clamp_coord(pos_x + walk_ofs + vel_x_next, X_MIN, X_MAX);
        pos_y_next = clamp_coord(pos_y + vel_y_next, Y_MIN, Y_MAX);
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vel_x <= '0;
            vel_y <= '0;
            pos_x <= coord_t'(`INIT_POS_X);
            pos_y <= coord_t'(`INIT_POS_Y);
        end else if (step_tick) begin
            vel_x <= vel_x_next;
            vel_y <= vel_y_next;
            pos_x <= pos_x_next;
            pos_y <= pos_y_next;
        end
    end

    a_pos_in_arena : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        pos_x >= X_MIN && pos_x <= X_MAX && pos_y >= Y_MIN && pos_y <= Y_MAX);

    a_vel_bounded : assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        vel_x >= -V_MAX && vel_x <= V_MAX && vel_y >= -V_MAX && vel_y <= V_MAX);

endmodule

`default_nettype wire

// ==== hw/character_top.sv ====
// Character controller top. step_tick is a one-cycle strobe in sys_clk;
// outputs change one cycle after each tick and hold in between.
`timescale 1ns/1ps
`default_nettype none

`include "character_params.svh"

module character_top (
    input  logic                        sys_clk,
    input  logic                        sys_rst_n,
    input  logic                        step_tick,
    input  logic                        left_btn,
    input  logic                        right_btn,
    input  logic                        jump_btn,
    output arena_pkg::coord_t           pos_x,
    output arena_pkg::coord_t           pos_y,
    output arena_pkg::vel_t             vel_x,
    output arena_pkg::vel_t             vel_y,
    output character_pkg::char_state_e  state,
    output character_pkg::face_e        face,
    output logic [`CHARGE_WIDTH-1:0]    charge,
    output logic                        on_ground
);

    import character_pkg::*;

    logic           left_held, right_held, jump_held;
    logic           jump_pending;
    logic           jump_taken;
    logic           side_hit;
    jump_strength_t strength;

    button_sync button_sync_i (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .left_btn     (left_btn),
        .right_btn    (right_btn),
        .jump_btn     (jump_btn),
        .jump_taken   (jump_taken),
        .left_held    (left_held),
        .right_held   (right_held),
        .jump_held    (jump_held),
        .jump_pending (jump_pending)
    );

    character_fsm character_fsm_i (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .step_tick    (step_tick),
        .left_held    (left_held),
        .right_held   (right_held),
        .jump_held    (jump_held),
        .jump_pending (jump_pending),
        .on_ground    (on_ground),
        .side_hit     (side_hit),
        .state        (state),
        .face         (face),
        .charge       (charge),
        .strength     (strength),
        .jump_taken   (jump_taken)
    );

    character_physics character_physics_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .step_tick (step_tick),
        .state     (state),
        .face      (face),
        .strength  (strength),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .vel_x     (vel_x),
        .vel_y     (vel_y),
        .on_ground (on_ground),
        .side_hit  (side_hit)
    );

endmodule

`default_nettype wire

// ==== verification/tb_character_top.sv ====
// Random button and step_tick stimulus for character_top, checked against a
// cycle model every clock. Inputs change 1 ns after the rising edge and the
// outputs are compared at that same point, after the registers settled.
`timescale 1ns/1ps
`default_nettype none

`include "character_params.svh"

module tb_character_top;

    import arena_pkg::*;
    import character_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int N_RESET     = 4;
    localparam int N_CYCLES    = 3000;
    localparam int WATCHDOG_NS = (N_RESET + N_CYCLES + 200) * CLK_PERIOD;

    logic sys_clk;
    logic sys_rst_n;
    logic step_tick;
    logic left_btn;
    logic right_btn;
    logic jump_btn;

    coord_t                   pos_x;
    coord_t                   pos_y;
    vel_t                     vel_x;
    vel_t                     vel_y;
    char_state_e              state;
    face_e                    face;
    logic [`CHARGE_WIDTH-1:0] charge;
    logic                     on_ground;

    // model registers
    char_state_e m_state;
    face_e       m_face;
    int          m_charge;
    int          m_vel_x, m_vel_y;
    int          m_pos_x, m_pos_y;
    logic        m_left_held, m_right_held, m_jump_held, m_jump_held_d;
    logic        m_jump_pending;

    logic [15:0] lfsr_state;
    int          run_left;
    logic        pat_left, pat_right, pat_jump, pat_short;
    int          coord_errs, vel_errs, state_errs, face_errs, value_errs;

    character_top character_top_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .step_tick (step_tick),
        .left_btn  (left_btn),
        .right_btn (right_btn),
        .jump_btn  (jump_btn),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .vel_x     (vel_x),
        .vel_y     (vel_y),
        .state     (state),
        .face      (face),
        .charge    (charge),
        .on_ground (on_ground)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // ------------------------------------------------------------------------
    // random source, 16 bit Galois LFSR
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int clamp_int(input int v, input int lo, input int hi);
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks
    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            coord_errs++;
        end
    endtask

    task automatic check_vel(input string name, input vel_t got, input vel_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            vel_errs++;
        end
    endtask

    task automatic check_state(input char_state_e got, input char_state_e exp);
        if (got !== exp) begin
            $display("error: state got 0x%h expected 0x%h at %0t", got, exp, $time);
            state_errs++;
        end
    endtask

    task automatic check_face(input face_e got, input face_e exp);
        if (got !== exp) begin
            $display("error: face got 0x%h expected 0x%h at %0t", got, exp, $time);
            face_errs++;
        end
    endtask

    task automatic check_value(input string name, input logic [`CHARGE_WIDTH-1:0] got,
                               input logic [`CHARGE_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    task automatic check_outputs();
        check_coord("pos_x", pos_x, coord_t'(m_pos_x));
        check_coord("pos_y", pos_y, coord_t'(m_pos_y));
        check_vel("vel_x", vel_x, vel_t'(m_vel_x));
        check_vel("vel_y", vel_y, vel_t'(m_vel_y));
        check_state(state, m_state);
        check_face(face, m_face);
        check_value("charge", charge, `CHARGE_WIDTH'(m_charge));
        check_value("on_ground", `CHARGE_WIDTH'(on_ground),
                    `CHARGE_WIDTH'(m_pos_y == `ARENA_Y_MIN));
    endtask

    // ------------------------------------------------------------------------
    // cycle model
    task automatic model_reset();
        m_state        = IDLE;
        m_face         = FACE_RIGHT;
        m_charge       = 1;
        m_vel_x        = 0;
        m_vel_y        = 0;
        m_pos_x        = `INIT_POS_X;
        m_pos_y        = `INIT_POS_Y;
        m_left_held    = 1'b0;
        m_right_held   = 1'b0;
        m_jump_held    = 1'b0;
        m_jump_held_d  = 1'b0;
        m_jump_pending = 1'b0;
    endtask

    task automatic model_step();
        logic        og, sh, np;
        int          factor, nvx, nvy, walk;
        char_state_e ns;
        np = (m_state == CHARGE) ? 1'b0 :
             ((m_jump_held && !m_jump_held_d) ? 1'b1 : m_jump_pending);
        if (step_tick) begin
            og = (m_pos_y == `ARENA_Y_MIN);
            sh = (m_pos_x == `ARENA_X_MIN && m_vel_x < 0) ||
                 (m_pos_x == `ARENA_X_MAX && m_vel_x > 0);
            factor = (m_charge <= 25) ? 1 : (m_charge <= 50) ? 2 : (m_charge <= 75) ? 3 : 4;
            if (m_state == CHARGE) begin
                ns = (!m_jump_held || m_charge >= `MAX_CHARGE) ? JUMP : CHARGE;
            end else if (m_state == JUMP || !og) begin
                ns = AIRBORNE;
            end else begin
                ns = m_left_held ? WALK_LEFT : m_right_held ? WALK_RIGHT :
                     m_jump_pending ? CHARGE : IDLE;
            end
            // horizontal then vertical velocity, both clamped
            if (m_state == JUMP) begin
                nvx = (m_face == FACE_LEFT) ? -(`JUMP_VEL_X * factor) : `JUMP_VEL_X * factor;
                nvy = `JUMP_VEL_Y * factor;
            end else begin
                nvx = sh ? -m_vel_x : (og ? 0 : m_vel_x);
                if (og && m_vel_y <= 0) begin
                    nvy = 0;
                end else if (m_pos_y == `ARENA_Y_MAX && m_vel_y > 0) begin
                    nvy = -m_vel_y;
                end else begin
                    nvy = m_vel_y - `GRAVITY;
                end
            end
            nvx  = clamp_int(nvx, -`MAX_VEL, `MAX_VEL);
            nvy  = clamp_int(nvy, -`MAX_VEL, `MAX_VEL);
            walk = (m_state == WALK_LEFT) ? -`WALK_STEP :
                   (m_state == WALK_RIGHT) ? `WALK_STEP : 0;
            m_pos_x = clamp_int(m_pos_x + walk + nvx, `ARENA_X_MIN, `ARENA_X_MAX);
            m_pos_y = clamp_int(m_pos_y + nvy, `ARENA_Y_MIN, `ARENA_Y_MAX);
            m_vel_x = nvx;
            m_vel_y = nvy;
            if (sh) begin
                m_face = (m_face == FACE_LEFT) ? FACE_RIGHT : FACE_LEFT;
            end else if (m_state == WALK_LEFT) begin
                m_face = FACE_LEFT;
            end else if (m_state == WALK_RIGHT) begin
                m_face = FACE_RIGHT;
            end
            if (m_state == CHARGE && m_charge < `MAX_CHARGE) begin
                m_charge = m_charge + `CHARGE_INCREMENT;
            end else if (m_state == JUMP) begin
                m_charge = 1;
            end
            m_state = ns;
        end
        m_jump_pending = np;
        m_jump_held_d  = m_jump_held;
        m_left_held    = left_btn;
        m_right_held   = right_btn;
        m_jump_held    = jump_btn;
    endtask

    // ------------------------------------------------------------------------
    // stimulus, buttons held for random runs
    task automatic choose_pattern();
        int sel;
        sel       = take_bits(3);
        pat_left  = 1'b0;
        pat_right = 1'b0;
        pat_jump  = 1'b0;
        pat_short = 1'b0;
        case (sel)
            2: begin pat_left = 1'b1;  run_left = 16 + take_bits(7); end
            3: begin pat_right = 1'b1; run_left = 16 + take_bits(7); end
            4, 5: begin pat_jump = 1'b1; run_left = 8 + take_bits(7); end
            6: begin pat_jump = 1'b1; pat_short = 1'b1; run_left = 8 + take_bits(5); end
            7: begin pat_left = 1'b1; pat_jump = 1'b1; run_left = 8 + take_bits(6); end
            default: run_left = 4 + take_bits(5);   // idle
        endcase
    endtask

    task automatic drive_inputs();
        if (run_left == 0) begin
            choose_pattern();
        end
        run_left--;
        step_tick = (take_bits(2) == 0);   // roughly one cycle in four
        left_btn  = pat_left;
        right_btn = pat_right;
        jump_btn  = pat_jump;
        if (pat_short) begin
            pat_jump = 1'b0;               // one cycle press only
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        sys_rst_n  = 1'b0;
        step_tick  = 1'b0;
        left_btn   = 1'b0;
        right_btn  = 1'b0;
        jump_btn   = 1'b0;
        lfsr_state = 16'd98;
        coord_errs = 0;
        vel_errs   = 0;
        state_errs = 0;
        face_errs  = 0;
        value_errs = 0;
        pat_left   = 1'b0;
        pat_right  = 1'b0;
        pat_jump   = 1'b0;
        pat_short  = 1'b0;
        run_left   = 60;                   // idle first so the character lands
        model_reset();
        repeat (N_RESET) @(posedge sys_clk);
        #1;
        sys_rst_n = 1'b1;
        check_outputs();
        drive_inputs();
        repeat (N_CYCLES) begin
            @(posedge sys_clk);
            model_step();
            #1;
            check_outputs();
            drive_inputs();
        end
        $display("errors: coord %0d, vel %0d, state %0d, face %0d, value %0d",
                 coord_errs, vel_errs, state_errs, face_errs, value_errs);
        if (coord_errs + vel_errs + state_errs + face_errs + value_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== character_top.f ====
+incdir+hw
hw/arena_pkg.sv
hw/character_pkg.sv
hw/button_sync.sv
hw/character_fsm.sv
hw/character_physics.sv
hw/character_top.sv
verification/tb_character_top.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv --top-module tb_character_top \
		-f character_top.f -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
